// ==== vlog.f ====
rtl/rv_exec_pkg.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/decode_unit.sv
rtl/alu_shifter.sv
rtl/execute_stage.sv
rtl/exec_core_top.sv
dv/tb_exec_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_exec_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Some tests failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "All tests passed" $(LOG) || { echo "Simulation did not finish"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_exec_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_exec_core;
    import rv_exec_pkg::*;

    logic        clk;
    logic        rst_i;
    logic        wb_cyc_o;
    logic        wb_stb_o;
    logic [31:0] wb_adr_o;
    logic [31:0] wb_dat_i;
    logic        wb_ack_i;
    retire_t     retire_o;

    logic [31:0] mem [0:1023];
    int          prog_len;
    logic [31:0] loop_pc;
    logic [31:0] mreg [0:31];
    logic [31:0] mpc;
    logic [31:0] rng_state;
    logic [31:0] delay_state;
    int          wait_left;
    retire_t     expected;
    logic        checking;
    int          loop_hits;
    int          n_ret;
    int          n_checks;
    int          n_errors;
    int          n_tests;
    int          test_errors;
    int          wd_cycles;
    int          wd_limit;

    exec_core_top UUT (
        .clk     (clk),
        .rst_i   (rst_i),
        .wb_cyc_o(wb_cyc_o),
        .wb_stb_o(wb_stb_o),
        .wb_adr_o(wb_adr_o),
        .wb_dat_i(wb_dat_i),
        .wb_ack_i(wb_ack_i),
        .retire_o(retire_o)
    );

    always #4 clk = !clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encoders and program builder.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[prog_len] = w;
        prog_len++;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) >> 12;
        emit(enc_u(upper[19:0], rd, OP_LUI));
        emit(enc_i(v[11:0], rd, 3'd0, rd, OP_IMM));
    endtask

    // Words outside a program decode as an unsupported opcode.
    task automatic clear_mem();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = {7'(i >> 3), 3'(i), 15'(i * 3), 7'b0000000};
        end
        prog_len = 0;
    endtask

    task automatic end_program();
        loop_pc = 32'(prog_len * 4);
        emit(enc_j(32'd0, 5'd0));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ISA reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic [31:0] a,
                                            input logic [31:0] b, input logic alt);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic retire_t iss_step();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] next_pc;
        logic        take;
        retire_t     r;
        ins     = mem[mpc[11:2]];
        a       = mreg[ins[19:15]];
        b       = mreg[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        next_pc = mpc + 32'd4;
        r       = '0;
        r.valid = 1'b1;
        r.pc    = mpc;
        r.rd    = ins[11:7];
        r.we    = 1'b1;
        case (ins[6:0])
            OP_LUI:   r.data = {ins[31:12], 12'b0};
            OP_AUIPC: r.data = mpc + {ins[31:12], 12'b0};
            OP_JAL: begin
                r.data  = mpc + 32'd4;
                next_pc = mpc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OP_JALR: begin
                r.data  = mpc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            OP_BRANCH: begin
                r.we = 1'b0;
                case (ins[14:12])
                    3'd0:    take = (a == b);
                    3'd1:    take = (a != b);
                    3'd4:    take = ($signed(a) < $signed(b));
                    3'd5:    take = ($signed(a) >= $signed(b));
                    3'd6:    take = (a < b);
                    default: take = (a >= b);
                endcase
                if (take) begin
                    next_pc = mpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            OP_IMM: begin
                r.data = ref_alu(ins[14:12], a, imm_i, ins[14:12] == 3'd5 && ins[30]);
            end
            default: r.data = ref_alu(ins[14:12], a, b, ins[30]);
        endcase
        if (r.we && r.rd != 5'd0) begin
            mreg[r.rd] = r.data;
        end
        mpc = next_pc;
        return r;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            test_errors++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Instruction memory with 0 to 3 wait states per read.
    always @(posedge clk) begin
        #1;
        if (wb_ack_i) begin
            wb_ack_i    = 1'b0;
            delay_state = xorshift(delay_state);
            wait_left   = int'(delay_state[1:0]);
        end else if (wb_stb_o && wb_cyc_o) begin
            if (wait_left == 0) begin
                wb_ack_i = 1'b1;
                wb_dat_i = mem[wb_adr_o[11:2]];
            end else begin
                wait_left--;
            end
        end
    end

    // Compare every retirement against the model.
    always @(posedge clk) begin
        if (checking && retire_o.valid) begin
            expected = iss_step();
            n_ret++;
            check(retire_o.pc, expected.pc, "retire pc");
            check(32'(retire_o.we), 32'(expected.we), "retire we");
            if (expected.we) begin
                check(32'(retire_o.rd), 32'(expected.rd), "retire rd");
                check(retire_o.data, expected.data, "retire data");
            end
            if (expected.pc == loop_pc) begin
                loop_hits++;
            end
        end
    end

    always @(posedge clk) begin
        if (checking) begin
            wd_cycles++;
            if (wd_cycles > wd_limit) begin
                $display("Timeout: the run stopped with retirements still missing");
                $display("Some tests failed");
                $finish;
            end
        end
    end

    task automatic start_test();
        @(posedge clk);
        #1;
        rst_i    = 1'b1;
        checking = 1'b0;
        clear_mem();
    endtask

    task automatic run_program(input string name);
        for (int i = 0; i < 32; i++) begin
            mreg[i] = '0;
        end
        mpc         = RESET_PC;
        loop_hits   = 0;
        n_ret       = 0;
        test_errors = 0;
        wd_cycles   = 0;
        wd_limit    = 200 * (prog_len + 3) + 200;
        repeat (3) @(posedge clk);
        #1;
        rst_i    = 1'b0;
        checking = 1'b1;
        while (loop_hits < 3) begin
            @(posedge clk);
        end
        #1;
        checking = 1'b0;
        n_tests++;
        $display("%s: retired %0d, errors %0d", name, n_ret, test_errors);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test programs.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic build_arith();
        logic [31:0] r;
        for (int round = 0; round < 4; round++) begin
            load_const(5'd1, next_rand());
            load_const(5'd2, next_rand());
            load_const(5'd3, next_rand() | 32'h1f);
            for (int f = 0; f < 8; f++) begin
                emit(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'(8 + f)));
            end
            emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd16));
            emit(enc_r(7'h20, 5'd3, 5'd1, 3'd5, 5'd17));
            emit(enc_r(7'h00, 5'd3, 5'd1, 3'd1, 5'd18));
            emit(enc_r(7'h00, 5'd3, 5'd1, 3'd5, 5'd19));
            for (int k = 0; k < 6; k++) begin
                r = next_rand();
                emit(enc_i(r[11:0], 5'd1, 3'(k == 0 ? 0 : k + 1 + (k > 3)),
                           5'(20 + k), OP_IMM));
            end
            emit(enc_i(12'h01f, 5'd2, 3'd1, 5'd26, OP_IMM));
            emit(enc_i(12'h01f, 5'd2, 3'd5, 5'd27, OP_IMM));
            emit(enc_i(12'h41f, 5'd2, 3'd5, 5'd28, OP_IMM));
        end
    endtask

    task automatic build_chain();
        logic [31:0] r;
        for (int round = 0; round < 4; round++) begin
            r = next_rand();
            load_const(5'd1, r);
            emit(enc_i(r[23:12], 5'd1, 3'd0, 5'd2, OP_IMM));
            emit(enc_r(7'h00, 5'd1, 5'd2, 3'd0, 5'd3));
            emit(enc_r(7'h20, 5'd2, 5'd3, 3'd0, 5'd4));
            emit(enc_r(7'h00, 5'd3, 5'd4, 3'd4, 5'd5));
            emit(enc_r(7'h00, 5'd4, 5'd5, 3'd6, 5'd6));
            emit(enc_r(7'h00, 5'd5, 5'd6, 3'd3, 5'd7));
            emit(enc_r(7'h00, 5'd6, 5'd7, 3'd0, 5'd1));
        end
    endtask

    task automatic build_branches();
        logic [31:0] av [0:2];
        logic [31:0] bv [0:2];
        logic [2:0]  conds [0:5];
        av = '{32'd7, 32'hffff_fffb, 32'd3};
        bv = '{32'd7, 32'd3, 32'hffff_fffb};
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int c = 0; c < 3; c++) begin
            load_const(5'd1, av[c]);
            load_const(5'd2, bv[c]);
            for (int k = 0; k < 6; k++) begin
                emit(enc_b(32'd12, 5'd2, 5'd1, conds[k]));
                emit(enc_i(12'd1, 5'd10, 3'd0, 5'd10, OP_IMM));
                emit(enc_i(12'd1, 5'd11, 3'd0, 5'd11, OP_IMM));
            end
        end
    endtask

    task automatic build_jumps();
        logic [31:0] r;
        r = next_rand();
        emit(enc_j(32'd12, 5'd1));
        emit(enc_i(12'd1, 5'd20, 3'd0, 5'd20, OP_IMM));
        emit(enc_i(12'd1, 5'd21, 3'd0, 5'd21, OP_IMM));
        emit(enc_u(r[19:0], 5'd5, OP_AUIPC));
        // The computed JALR target is odd and lands four words on.
        emit(enc_u(20'd0, 5'd6, OP_AUIPC));
        emit(enc_i(12'd17, 5'd6, 3'd0, 5'd6, OP_IMM));
        emit(enc_i(12'd0, 5'd6, 3'd0, 5'd7, OP_JALR));
        emit(enc_i(12'd1, 5'd8, 3'd0, 5'd8, OP_IMM));
        emit(enc_j(32'd8, 5'd1));
        emit(enc_j(32'd8, 5'd2));
        emit(enc_j(32'hffff_fffc, 5'd3));
        emit(enc_u(20'd0, 5'd12, OP_AUIPC));
        emit(enc_i(12'd33, 5'd12, 3'd0, 5'd12, OP_IMM));
        emit(enc_i(12'hff3, 5'd12, 3'd0, 5'd13, OP_JALR));
        emit(enc_i(12'd1, 5'd14, 3'd0, 5'd14, OP_IMM));
        emit(enc_i(12'd1, 5'd15, 3'd0, 5'd15, OP_IMM));
        emit(enc_r(7'h00, 5'd13, 5'd7, 3'd0, 5'd16));
    endtask

    task automatic build_random();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [2:0]  conds [0:5];
        int          start;
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        emit(enc_i(12'd77, 5'd0, 3'd0, 5'd0, OP_IMM));
        emit(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd1));
        emit(enc_u(20'h12345, 5'd0, OP_LUI));
        emit(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd2));
        for (int k = 3; k < 8; k++) begin
            load_const(5'(k), next_rand());
        end
        start = prog_len;
        while (prog_len - start < 200) begin
            r  = next_rand();
            f3 = r[10:8];
            if (r[2:0] <= 3'd2) begin
                emit(enc_r({1'b0, r[31] && (f3 == 3'd0 || f3 == 3'd5), 5'd0},
                           {2'b00, r[15:13]}, {2'b00, r[18:16]}, f3, {2'b00, r[21:19]}));
            end else if (r[2:0] <= 3'd4) begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    emit(enc_i({1'b0, r[31] && f3 == 3'd5, 5'd0, r[26:22]},
                               {2'b00, r[18:16]}, f3, {2'b00, r[21:19]}, OP_IMM));
                end else begin
                    emit(enc_i(r[31:20], {2'b00, r[18:16]}, f3, {2'b00, r[13:11]}, OP_IMM));
                end
            end else if (r[2:0] == 3'd5) begin
                emit(enc_u(r[31:12], {2'b00, r[7:5]}, OP_LUI));
            end else if (r[2:0] == 3'd6 || 200 - (prog_len - start) < 3) begin
                emit(enc_u(r[31:12], {2'b00, r[7:5]}, OP_AUIPC));
            end else if (r[3]) begin
                emit(enc_j(32'd8, {2'b00, r[7:5]}));
            end else begin
                emit(enc_b(r[4] ? 32'd12 : 32'd8, {2'b00, r[15:13]}, {2'b00, r[18:16]},
                           conds[32'(r[30:20]) % 6]));
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_i       = 1'b1;
        wb_dat_i    = '0;
        wb_ack_i    = 1'b0;
        checking    = 1'b0;
        rng_state   = 32'hc8d;
        delay_state = xorshift(32'hc8d ^ 32'h5a5a_0f0f);
        wait_left   = 0;
        loop_pc     = '0;
        n_checks    = 0;
        n_errors    = 0;
        n_tests     = 0;
        wd_cycles   = 0;
        wd_limit    = 1000;
        start_test();
        build_arith();
        end_program();
        run_program("arith");
        start_test();
        build_chain();
        end_program();
        run_program("forwarding");
        start_test();
        build_branches();
        end_program();
        run_program("branches");
        start_test();
        build_jumps();
        end_program();
        run_program("jumps");
        start_test();
        build_random();
        end_program();
        run_program("random");
        $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/exec_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_core_top #(
    parameter int              XLEN     = rv_exec_pkg::XLEN,
    parameter logic [XLEN-1:0] RESET_PC = rv_exec_pkg::RESET_PC
) (
    input  wire                  clk,
    input  wire                  rst_i,
    output logic                 wb_cyc_o,
    output logic                 wb_stb_o,
    output logic [XLEN-1:0]      wb_adr_o,
    input  wire  [31:0]          wb_dat_i,
    input  wire                  wb_ack_i,
    output rv_exec_pkg::retire_t retire_o
);
    import rv_exec_pkg::*;

    if_id_t          if_id;
    id_ex_t          id_ex;
    redirect_t       redirect;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    fetch_unit #(
        .XLEN    (XLEN),
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk       (clk),
        .rst_i     (rst_i),
        .redirect_i(redirect),
        .wb_cyc_o  (wb_cyc_o),
        .wb_stb_o  (wb_stb_o),
        .wb_adr_o  (wb_adr_o),
        .wb_dat_i  (wb_dat_i),
        .wb_ack_i  (wb_ack_i),
        .if_id_o   (if_id)
    );

    reg_file #(.XLEN(XLEN)) u_regs (
        .clk       (clk),
        .rst_i     (rst_i),
        .rs1_addr_i(rs1_addr),
        .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data),
        .wr_i      (retire_o)
    );

    decode_unit #(.XLEN(XLEN)) u_decode (
        .clk       (clk),
        .rst_i     (rst_i),
        .if_id_i   (if_id),
        .redirect_i(redirect),
        .rs1_addr_o(rs1_addr),
        .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .id_ex_o   (id_ex)
    );

    execute_stage #(.XLEN(XLEN)) u_execute (
        .clk       (clk),
        .rst_i     (rst_i),
        .id_ex_i   (id_ex),
        .redirect_o(redirect),
        .retire_o  (retire_o)
    );

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage #(
    parameter int XLEN = rv_exec_pkg::XLEN
) (
    input  wire                    clk,
    input  wire                    rst_i,
    input  rv_exec_pkg::id_ex_t    id_ex_i,
    output rv_exec_pkg::redirect_t redirect_o,
    output rv_exec_pkg::retire_t   retire_o
);
    import rv_exec_pkg::*;

    retire_t         ret_q;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] pc_rel;
    logic            zero;
    logic            neg;
    logic            ltu;
    logic            taken;

    // The only younger result not yet in the register file sits in ret_q.
    function automatic logic [XLEN-1:0] fwd(input logic [4:0] num, input logic [XLEN-1:0] val);
        if (ret_q.valid && ret_q.we && ret_q.rd != 5'd0 && ret_q.rd == num) begin
            return ret_q.data;
        end
        return val;
    endfunction

    assign rs1_val = fwd(id_ex_i.rs1, id_ex_i.rs1_val);
    assign rs2_val = fwd(id_ex_i.rs2, id_ex_i.rs2_val);
    assign alu_a   = id_ex_i.sel_a_pc ? id_ex_i.pc : rs1_val;
    assign alu_b   = id_ex_i.sel_b_imm ? id_ex_i.imm : rs2_val;
    assign pc_rel  = id_ex_i.pc + id_ex_i.imm;

    alu_shifter #(
        .XLEN(XLEN)
    ) u_alu (
        .a_i     (alu_a),
        .b_i     (alu_b),
        .op_i    (id_ex_i.alu_op),
        .result_o(alu_res),
        .zero_o  (zero),
        .neg_o   (neg),
        .ltu_o   (ltu)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Branch controller; not-taken is predicted, so taken redirects.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (id_ex_i.br_cond)
            BR_EQ:     taken = zero;
            BR_NE:     taken = !zero;
            BR_LT:     taken = neg;
            BR_GE:     taken = !neg;
            BR_LTU:    taken = ltu;
            BR_GEU:    taken = !ltu;
            BR_ALWAYS: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign redirect_o.valid  = id_ex_i.valid && taken;
    assign redirect_o.target = id_ex_i.is_jalr ? {alu_res[XLEN-1:1], 1'b0} : pc_rel;

    // Writeback register.
    always_ff @(posedge clk) begin
        ret_q.pc   <= id_ex_i.pc;
        ret_q.rd   <= id_ex_i.rd;
        ret_q.we   <= id_ex_i.writes_rd;
        ret_q.data <= id_ex_i.is_jump ? id_ex_i.pc + XLEN'(4) : alu_res;
        ret_q.valid <= id_ex_i.valid && !rst_i;
    end

    assign retire_o = ret_q;

endmodule

`default_nettype wire

// ==== rtl/alu_shifter.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_shifter #(
    parameter int XLEN = rv_exec_pkg::XLEN
) (
    input  wire  [XLEN-1:0]      a_i,
    input  wire  [XLEN-1:0]      b_i,
    input  rv_exec_pkg::alu_op_e op_i,
    output logic [XLEN-1:0]      result_o,
    output logic                 zero_o,
    output logic                 neg_o,
    output logic                 ltu_o
);
    import rv_exec_pkg::*;

    logic [XLEN:0]   diff;
    logic            ovf;
    logic [4:0]      shamt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Flags from a minus b.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign diff   = {1'b0, a_i} - {1'b0, b_i};
    assign ltu_o  = diff[XLEN];
    assign zero_o = (diff[XLEN-1:0] == '0);
    assign ovf    = (a_i[XLEN-1] ^ b_i[XLEN-1]) & (a_i[XLEN-1] ^ diff[XLEN-1]);
    // With overflow corrected, neg means a is less than b as signed numbers.
    assign neg_o  = diff[XLEN-1] ^ ovf;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = diff[XLEN-1:0];
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, neg_o};
            ALU_SLTU:   result_o = {{(XLEN-1){1'b0}}, ltu_o};
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SRL:    result_o = a_i >> shamt;
            ALU_SRA:    result_o = $signed(a_i) >>> shamt;
            ALU_OR:     result_o = a_i | b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_PASS_B: result_o = b_i;
            default:    result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/decode_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_unit #(
    parameter int XLEN = rv_exec_pkg::XLEN
) (
    input  wire                    clk,
    input  wire                    rst_i,
    input  rv_exec_pkg::if_id_t    if_id_i,
    input  rv_exec_pkg::redirect_t redirect_i,
    output logic [4:0]             rs1_addr_o,
    output logic [4:0]             rs2_addr_o,
    input  wire  [XLEN-1:0]        rs1_data_i,
    input  wire  [XLEN-1:0]        rs2_data_i,
    output rv_exec_pkg::id_ex_t    id_ex_o
);
    import rv_exec_pkg::*;

    instr_u ins;
    id_ex_t dec;
    id_ex_t id_ex_q;

    assign ins        = if_id_i.instr;
    assign rs1_addr_o = ins.i.rs1;
    assign rs2_addr_o = ins.s.rs2;

    // Register and immediate forms share this map; only OP_REG knows SUB.
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt,
                                                input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        dec         = '0;
        dec.valid   = if_id_i.valid;
        dec.pc      = if_id_i.pc;
        dec.rs1     = ins.i.rs1;
        dec.rs2     = ins.s.rs2;
        dec.rs1_val = rs1_data_i;
        dec.rs2_val = rs2_data_i;
        dec.rd      = ins.r.rd;
        dec.alu_op  = ALU_ADD;
        dec.br_cond = BR_NONE;
        case (ins.r.opcode)
            OP_LUI, OP_AUIPC: begin
                dec.imm       = {ins.u.imm, 12'b0};
                dec.alu_op    = (ins.u.opcode == OP_LUI) ? ALU_PASS_B : ALU_ADD;
                dec.sel_a_pc  = (ins.u.opcode == OP_AUIPC);
                dec.sel_b_imm = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OP_JAL: begin
                dec.imm = {{12{ins.u.imm[19]}}, ins.u.imm[7:0], ins.u.imm[8],
                           ins.u.imm[18:9], 1'b0};
                dec.br_cond   = BR_ALWAYS;
                dec.is_jump   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OP_JALR: begin
                dec.imm       = {{20{ins.i.imm[11]}}, ins.i.imm};
                dec.sel_b_imm = 1'b1;
                dec.br_cond   = BR_ALWAYS;
                dec.is_jump   = 1'b1;
                dec.is_jalr   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OP_BRANCH: begin
                dec.imm = {{20{ins.b.imm12}}, ins.b.imm11, ins.b.imm10_5,
                           ins.b.imm4_1, 1'b0};
                // The comparison is a subtraction whose flags execute reads.
                dec.alu_op = ALU_SUB;
                case (ins.b.funct3)
                    3'b000:  dec.br_cond = BR_EQ;
                    3'b001:  dec.br_cond = BR_NE;
                    3'b100:  dec.br_cond = BR_LT;
                    3'b101:  dec.br_cond = BR_GE;
                    3'b110:  dec.br_cond = BR_LTU;
                    3'b111:  dec.br_cond = BR_GEU;
                    default: dec.valid   = 1'b0;
                endcase
            end
            OP_IMM: begin
                dec.imm       = {{20{ins.i.imm[11]}}, ins.i.imm};
                dec.alu_op    = alu_from_funct3(ins.i.funct3, ins.r.funct7[5], 1'b0);
                dec.sel_b_imm = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OP_REG: begin
                dec.alu_op    = alu_from_funct3(ins.r.funct3, ins.r.funct7[5], 1'b1);
                dec.writes_rd = 1'b1;
            end
            default: dec.valid = 1'b0;
        endcase
    end

    // Payload loads every cycle, and only valid is cleared.
    always_ff @(posedge clk) begin
        id_ex_q <= dec;
        if (rst_i || redirect_i.valid) begin
            id_ex_q.valid <= 1'b0;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file #(
    parameter int XLEN = rv_exec_pkg::XLEN
) (
    input  wire                  clk,
    input  wire                  rst_i,
    input  wire  [4:0]           rs1_addr_i,
    input  wire  [4:0]           rs2_addr_i,
    output logic [XLEN-1:0]      rs1_data_o,
    output logic [XLEN-1:0]      rs2_data_o,
    input  rv_exec_pkg::retire_t wr_i
);

    logic [XLEN-1:0] regs_q [1:31];
    logic            wr_en;

    assign wr_en = wr_i.valid && wr_i.we && (wr_i.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wr_i.rd] <= wr_i.data;
        end
    end

    // A write in this cycle is seen by a read of the same register.
    function automatic logic [XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        return (wr_en && wr_i.rd == addr) ? wr_i.data : regs_q[addr];
    endfunction

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
    parameter int              XLEN     = rv_exec_pkg::XLEN,
    parameter logic [XLEN-1:0] RESET_PC = rv_exec_pkg::RESET_PC
) (
    input  wire                    clk,
    input  wire                    rst_i,
    input  rv_exec_pkg::redirect_t redirect_i,
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic [XLEN-1:0]        wb_adr_o,
    input  wire  [31:0]            wb_dat_i,
    input  wire                    wb_ack_i,
    output rv_exec_pkg::if_id_t    if_id_o
);
    import rv_exec_pkg::*;

    logic            cyc_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] target_q;
    logic            discard_q;
    logic            read_done;
    if_id_t          if_id_q;

    // The bus stays busy after reset, so every ack ends one read and opens the next.
    assign wb_cyc_o  = cyc_q;
    assign wb_stb_o  = cyc_q;
    assign wb_adr_o  = pc_q;
    assign read_done = cyc_q && wb_ack_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cyc_q     <= 1'b0;
            pc_q      <= RESET_PC;
            discard_q <= 1'b0;
        end else begin
            cyc_q <= 1'b1;
            if (redirect_i.valid) begin
                if (read_done || !cyc_q) begin
                    pc_q      <= redirect_i.target;
                    discard_q <= 1'b0;
                end else begin
                    // The address must hold until ack, so the target waits here.
                    discard_q <= 1'b1;
                end
            end else if (read_done) begin
                pc_q      <= discard_q ? target_q : pc_q + XLEN'(4);
                discard_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_i.valid) begin
            target_q <= redirect_i.target;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch-to-decode register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (read_done) begin
            if_id_q.pc    <= pc_q;
            if_id_q.instr <= wb_dat_i;
        end
        // A word fetched down the wrong path never reaches decode.
        if_id_q.valid <= read_done && !discard_q && !redirect_i.valid && !rst_i;
    end

    assign if_id_o = if_id_q;

endmodule

`default_nettype wire

// ==== rtl/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcodes of the supported RV32I subset.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // The J format shares this view and regroups imm in the decoder.
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
    } br_cond_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline records.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_u          instr;
    } if_id_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [XLEN-1:0] imm;
        alu_op_e         alu_op;
        logic            sel_a_pc;
        logic            sel_b_imm;
        br_cond_e        br_cond;
        logic            is_jump;
        logic            is_jalr;
        logic [4:0]      rd;
        logic            writes_rd;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic            we;
        logic [XLEN-1:0] data;
    } retire_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire
